/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_corr_subsystem
FILELIST  ?= corr_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(wildcard *.sv *.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bit_correlator.sv */
`include "corr_params.svh"

module bit_correlator
  import corr_pkg::*;
#(
  parameter int CODE_SEL = 0
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       in_valid,
  output logic       in_ready,
  input  beat_t      in_beat,
  output logic       out_valid,
  input  logic       out_ready,
  output corr_beat_t out_beat
);

  localparam int LEN = `CORR_LEN;
  localparam int NCH = `CORR_NUM_CHAN;
  localparam chan_t LAST_CHAN = chan_t'(NCH - 1);
  localparam logic [LEN-1:0] CODE = (CODE_SEL == 0) ? `CORR_CODE_A : `CORR_CODE_B;

  // control
  chan_t     cnt;
  logic      run;
  logic      pend;
  logic      load;
  logic      enable;
  logic      at_last;
  logic      take;
  logic      last_upd;
  beat_idx_t beat_cnt;

  // payload
  beat_t     beat_q;
  beat_idx_t idx_q;
  beat_idx_t col_idx;
  sample_t   smp_cur;
  acc_t      x_ext;
  acc_t      chain_in  [LEN];
  acc_t      chain_out [LEN];
  acc_t      stage_mem [LEN-1][NCH];
  acc_t      out_col   [NCH];

  //////////////////////////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////////////////////////

  // stall only once the finished column and the output reg are both full
  assign load     = !out_valid || out_ready;
  assign enable   = !(pend && !load);
  assign at_last  = (cnt == LAST_CHAN);
  assign in_ready = enable && at_last;
  assign take     = in_valid && in_ready;
  assign last_upd = enable && run && at_last;

  // counter parks on the last channel until the next beat arrives
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt      <= '0;
      run      <= 1'b0;
      beat_cnt <= '0;
    end else if (enable) begin
      if (!at_last) begin
        cnt <= cnt + 1'b1;
      end else if (take) begin
        cnt <= '0;
      end
      if (at_last) begin
        run <= take;
      end
      if (take) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      beat_q <= in_beat;
      idx_q  <= beat_cnt;
    end
    if (last_upd) begin
      col_idx <= idx_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // transposed adder chain
  //////////////////////////////////////////////////////////////////////

  assign smp_cur = beat_q.smp[cnt];
  assign x_ext   = acc_t'(smp_cur);

  for (genvar n = 0; n < LEN; n++) begin : g_chain
    if (n == 0) begin : g_head
      assign chain_in[n] = '0;
    end else begin : g_tap
      assign chain_in[n] = stage_mem[n-1][cnt];
    end
    // stage n sees the sample that is LEN-1-n beats old at the output
    assign chain_out[n] = CODE[LEN-1-n] ? chain_in[n] + x_ext : chain_in[n] - x_ext;
  end

  // history must start at zero so pre-reset samples count as zero
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int n = 0; n < LEN - 1; n++) begin
        for (int c = 0; c < NCH; c++) begin
          stage_mem[n][c] <= '0;
        end
      end
    end else if (enable && run) begin
      for (int n = 1; n < LEN; n++) begin
        stage_mem[n-1][cnt] <= chain_out[n-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (enable && run) begin
      out_col[cnt] <= chain_out[LEN-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend      <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (last_upd) begin
        pend <= 1'b1;
      end else if (load) begin
        pend <= 1'b0;
      end
      if (load) begin
        out_valid <= pend;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load && pend) begin
      for (int c = 0; c < NCH; c++) begin
        out_beat.acc[c] <= out_col[c];
      end
      out_beat.beat <= col_idx;
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

/* corr_params.svh */
`ifndef CORR_PARAMS_SVH
`define CORR_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

`define CORR_NUM_CHAN    4
`define CORR_SAMPLE_W    8
`define CORR_ACC_W       12
`define CORR_BEAT_W      16

//////////////////////////////////////////////////////////////////////
// spreading codes
//////////////////////////////////////////////////////////////////////

// bit k set gives lag k a weight of +1, clear gives -1
`define CORR_LEN         8
`define CORR_CODE_A      8'b1011_0010
`define CORR_CODE_B      8'b0110_1010

// peak magnitude that raises an event
`define CORR_THRESHOLD   400

// event log
`define CORR_EV_DEPTH    32

`endif

/* corr_pkg.sv */
`include "corr_params.svh"

package corr_pkg;

  // scalar widths
  typedef logic signed [`CORR_SAMPLE_W-1:0] sample_t;
  typedef logic signed [`CORR_ACC_W-1:0] acc_t;
  typedef logic [$clog2(`CORR_NUM_CHAN)-1:0] chan_t;
  typedef logic [`CORR_BEAT_W-1:0] beat_idx_t;
  typedef logic [$clog2(`CORR_EV_DEPTH)-1:0] ev_addr_t;

  // one input beat, one sample per channel
  typedef struct packed {
    sample_t [`CORR_NUM_CHAN-1:0] smp;
  } beat_t;

  // one correlator result column tagged with its input beat
  typedef struct packed {
    acc_t [`CORR_NUM_CHAN-1:0] acc;
    beat_idx_t                 beat;
  } corr_beat_t;

  // logged peak
  typedef struct packed {
    logic      src;
    chan_t     chan;
    beat_idx_t beat;
    acc_t      value;
  } corr_event_t;

  // round-robin preference between the two detectors
  typedef enum logic {
    ARB_PREFER_A,
    ARB_PREFER_B
  } arb_state_t;

endpackage

/* corr_subsystem.f */
+incdir+.
corr_pkg.sv
bit_correlator.sv
peak_detector.sv
event_arbiter.sv
event_buffer.sv
corr_subsystem.sv
tb_corr_subsystem.sv

/* corr_subsystem.sv */
`include "corr_params.svh"

module corr_subsystem
  import corr_pkg::*;
(
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               s_valid,
  output logic                               s_ready,
  input  beat_t                              s_data,
  input  ev_addr_t                           rd_addr,
  output corr_event_t                        rd_event,
  output logic [$clog2(`CORR_EV_DEPTH):0]    ev_count,
  output logic                               overflow
);

  logic        rdy_a;
  logic        rdy_b;
  logic        beat_valid;
  logic        cv_a;
  logic        cv_b;
  logic        cr_a;
  logic        cr_b;
  logic        det_ready;
  logic        dv_a;
  logic        dv_b;
  corr_beat_t  cb_a;
  corr_beat_t  cb_b;
  logic        req_a;
  logic        req_b;
  logic        grant_a;
  logic        grant_b;
  corr_event_t ev_a;
  corr_event_t ev_b;
  logic        wr_en;
  corr_event_t wr_event;

  // both correlators take every beat together
  assign s_ready    = rdy_a && rdy_b;
  assign beat_valid = s_valid && s_ready;

  // a column moves on only when both detectors are idle
  assign det_ready = cr_a && cr_b;
  assign dv_a      = cv_a && det_ready;
  assign dv_b      = cv_b && det_ready;

  bit_correlator #(.CODE_SEL(0)) corr_a (
    .clk(clk), .arst_n(arst_n),
    .in_valid(beat_valid), .in_ready(rdy_a), .in_beat(s_data),
    .out_valid(cv_a), .out_ready(det_ready), .out_beat(cb_a)
  );

  bit_correlator #(.CODE_SEL(1)) corr_b (
    .clk(clk), .arst_n(arst_n),
    .in_valid(beat_valid), .in_ready(rdy_b), .in_beat(s_data),
    .out_valid(cv_b), .out_ready(det_ready), .out_beat(cb_b)
  );

  peak_detector #(.SRC(1'b0)) det_a (
    .clk(clk), .arst_n(arst_n),
    .in_valid(dv_a), .in_ready(cr_a), .in_beat(cb_a),
    .req(req_a), .ev(ev_a), .grant(grant_a)
  );

  peak_detector #(.SRC(1'b1)) det_b (
    .clk(clk), .arst_n(arst_n),
    .in_valid(dv_b), .in_ready(cr_b), .in_beat(cb_b),
    .req(req_b), .ev(ev_b), .grant(grant_b)
  );

  event_arbiter event_arbiter (
    .clk(clk), .arst_n(arst_n),
    .req_a(req_a), .req_b(req_b), .ev_a(ev_a), .ev_b(ev_b),
    .grant_a(grant_a), .grant_b(grant_b),
    .wr_en(wr_en), .wr_event(wr_event)
  );

  event_buffer event_buffer (
    .clk(clk), .arst_n(arst_n),
    .wr_en(wr_en), .wr_event(wr_event),
    .rd_addr(rd_addr), .rd_event(rd_event),
    .ev_count(ev_count), .overflow(overflow)
  );

  // the detectors differ in timing, but the correlators must not drift apart
  a_lockstep: assert property (@(posedge clk) disable iff (!arst_n)
    rdy_a == rdy_b);

endmodule

/* event_arbiter.sv */
module event_arbiter
  import corr_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        req_a,
  input  logic        req_b,
  input  corr_event_t ev_a,
  input  corr_event_t ev_b,
  output logic        grant_a,
  output logic        grant_b,
  output logic        wr_en,
  output corr_event_t wr_event
);

  arb_state_t pref;
  logic       want_a;
  logic       want_b;
  logic       pick_a;
  logic       pick_b;

  // req drops one cycle after grant, so mask the side granted just now
  assign want_a = req_a && !grant_a;
  assign want_b = req_b && !grant_b;
  assign pick_a = want_a && (!want_b || pref == ARB_PREFER_A);
  assign pick_b = want_b && !pick_a;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pref    <= ARB_PREFER_A;
      grant_a <= 1'b0;
      grant_b <= 1'b0;
      wr_en   <= 1'b0;
    end else begin
      grant_a <= pick_a;
      grant_b <= pick_b;
      wr_en   <= pick_a || pick_b;
      // preference goes to the side that lost or waited
      if (pick_a) begin
        pref <= ARB_PREFER_B;
      end else if (pick_b) begin
        pref <= ARB_PREFER_A;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pick_a) begin
      wr_event <= ev_a;
    end else if (pick_b) begin
      wr_event <= ev_b;
    end
  end

  a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
    !(grant_a && grant_b));

endmodule

/* event_buffer.sv */
`include "corr_params.svh"

module event_buffer
  import corr_pkg::*;
(
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               wr_en,
  input  corr_event_t                        wr_event,
  input  ev_addr_t                           rd_addr,
  output corr_event_t                        rd_event,
  output logic [$clog2(`CORR_EV_DEPTH):0]    ev_count,
  output logic                               overflow
);

  localparam int DEPTH = `CORR_EV_DEPTH;

  corr_event_t mem [DEPTH];
  ev_addr_t    wr_ptr;
  logic        full;

  // events are appended in arrival order
  assign wr_ptr = ev_addr_t'(ev_count);
  assign full   = (ev_count == DEPTH);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ev_count <= '0;
      overflow <= 1'b0;
    end else if (wr_en) begin
      if (full) begin
        overflow <= 1'b1;
      end else begin
        ev_count <= ev_count + 1'b1;
      end
    end
  end

  // storage and registered read port
  always_ff @(posedge clk) begin
    if (wr_en && !full) begin
      mem[wr_ptr] <= wr_event;
    end
    rd_event <= mem[rd_addr];
  end

endmodule

/* peak_detector.sv */
`include "corr_params.svh"

module peak_detector
  import corr_pkg::*;
#(
  parameter logic SRC = 1'b0
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        in_valid,
  output logic        in_ready,
  input  corr_beat_t  in_beat,
  output logic        req,
  output corr_event_t ev,
  input  logic        grant
);

  typedef enum logic [1:0] {
    DET_IDLE,
    DET_SCAN,
    DET_WAIT
  } det_state_t;

  localparam chan_t LAST_CHAN = chan_t'(`CORR_NUM_CHAN - 1);

  det_state_t state;
  chan_t      idx;
  corr_beat_t beat_q;
  acc_t       cur;
  acc_t       mag;
  logic       hit;
  logic       last_chan;

  assign in_ready  = (state == DET_IDLE);
  assign cur       = beat_q.acc[idx];
  assign mag       = cur[`CORR_ACC_W-1] ? -cur : cur;
  assign hit       = (mag >= acc_t'(`CORR_THRESHOLD));
  assign last_chan = (idx == LAST_CHAN);

  // one channel per cycle, parking in DET_WAIT for each hit
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= DET_IDLE;
      idx   <= '0;
      req   <= 1'b0;
    end else begin
      case (state)
        DET_IDLE: begin
          if (in_valid) begin
            idx   <= '0;
            state <= DET_SCAN;
          end
        end
        DET_SCAN: begin
          if (hit) begin
            req   <= 1'b1;
            state <= DET_WAIT;
          end else if (last_chan) begin
            state <= DET_IDLE;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        DET_WAIT: begin
          if (grant) begin
            req <= 1'b0;
            if (last_chan) begin
              state <= DET_IDLE;
            end else begin
              idx   <= idx + 1'b1;
              state <= DET_SCAN;
            end
          end
        end
        default: state <= DET_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      beat_q <= in_beat;
    end
    if (state == DET_SCAN && hit) begin
      ev <= '{src: SRC, chan: idx, beat: beat_q.beat, value: cur};
    end
  end

  a_grant_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    grant |-> req);

endmodule

/* tb_corr_subsystem.sv */
`include "corr_params.svh"

module tb_corr_subsystem
  import corr_pkg::*;
();

  localparam int NCH = `CORR_NUM_CHAN;
  localparam int LEN = `CORR_LEN;
  localparam int DEPTH = `CORR_EV_DEPTH;
  localparam int THR = `CORR_THRESHOLD;
  localparam logic [LEN-1:0] CODE_A = `CORR_CODE_A;
  localparam logic [LEN-1:0] CODE_B = `CORR_CODE_B;
  localparam int N_ROWS = 98;
  localparam int N_TESTS = 5;
  // enough for a few held beats to drain through both detectors
  localparam int DRAIN_CYCLES = 96;
  localparam int CYCLE_LIMIT = N_ROWS * 40;

  logic                            clk;
  logic                            arst_n;
  logic                            s_valid;
  logic                            s_ready;
  beat_t                           s_data;
  ev_addr_t                        rd_addr;
  corr_event_t                     rd_event;
  logic [$clog2(`CORR_EV_DEPTH):0] ev_count;
  logic                            overflow;

  // stimulus table with one row range per test
  sample_t tbl_smp [N_ROWS][NCH];
  int      tbl_gap [N_ROWS];
  int      test_first [N_TESTS] = '{0, 6, 18, 42, 66};
  int      test_len [N_TESTS] = '{6, 12, 24, 24, 32};
  string   test_name [N_TESTS] = '{"zero input", "matched code", "two-source scan",
                                   "back-pressure", "overflow"};

  logic [31:0] rng_state;
  corr_event_t exp_q [$];
  corr_event_t got_q [$];
  int          err_cnt;
  int          check_cnt;
  int          fail_tests;
  int          cycle_cnt;

  corr_subsystem corr_subsystem_inst (
    .clk(clk), .arst_n(arst_n),
    .s_valid(s_valid), .s_ready(s_ready), .s_data(s_data),
    .rd_addr(rd_addr), .rd_event(rd_event),
    .ev_count(ev_count), .overflow(overflow)
  );

  always #50 clk = ~clk;

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run timed out after %0d cycles", cycle_cnt);
    $display("CHECKS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check(input int got, input int want, input string what);
    check_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("CHECK FAILED at time %0t: %s, got %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic build_table();
    logic [31:0] r;
    int          row;
    row = 0;
    for (int i = 0; i < 6; i++) begin
      for (int c = 0; c < NCH; c++) tbl_smp[row][c] = '0;
      tbl_gap[row] = i % 3;
      row++;
    end
    // code A on channel 2 with the oldest lag first so the full match lands on beat 7
    for (int j = 0; j < 12; j++) begin
      for (int c = 0; c < NCH; c++) tbl_smp[row][c] = '0;
      if (j < LEN) begin
        tbl_smp[row][2] = CODE_A[LEN-1-j] ? sample_t'(50) : sample_t'(-50);
      end
      tbl_gap[row] = j % 2;
      row++;
    end
    for (int i = 0; i < 48; i++) begin
      for (int c = 0; c < NCH; c++) begin
        r = next_rand();
        tbl_smp[row][c] = sample_t'(r[7:0]);
      end
      r = next_rand();
      // second random block keeps s_valid high all the way
      tbl_gap[row] = (i < 24) ? int'(r[1:0]) : 0;
      row++;
    end
    // large +-120 samples hit the threshold often
    for (int i = 0; i < 32; i++) begin
      for (int c = 0; c < NCH; c++) begin
        r = next_rand();
        tbl_smp[row][c] = r[0] ? sample_t'(120) : sample_t'(-120);
      end
      tbl_gap[row] = 0;
      row++;
    end
  endtask

  // reference correlation with events in beat then channel order
  task automatic run_model(input int first, input int count);
    int             hist [NCH][LEN];
    int             sum;
    logic [LEN-1:0] code;
    corr_event_t    e;
    exp_q.delete();
    for (int c = 0; c < NCH; c++) begin
      for (int k = 0; k < LEN; k++) hist[c][k] = 0;
    end
    for (int t = 0; t < count; t++) begin
      for (int c = 0; c < NCH; c++) begin
        for (int k = LEN - 1; k > 0; k--) hist[c][k] = hist[c][k-1];
        hist[c][0] = int'(tbl_smp[first+t][c]);
        for (int s = 0; s < 2; s++) begin
          code = (s == 0) ? CODE_A : CODE_B;
          sum = 0;
          for (int k = 0; k < LEN; k++) sum += code[k] ? hist[c][k] : -hist[c][k];
          if (sum >= THR || sum <= -THR) begin
            e.src   = (s == 1);
            e.chan  = chan_t'(c);
            e.beat  = beat_idx_t'(t);
            e.value = acc_t'(sum);
            exp_q.push_back(e);
          end
        end
      end
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    arst_n  <= 1'b0;
    s_valid <= 1'b0;
    rd_addr <= '0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  task automatic send_rows(input int first, input int count);
    logic ready_seen;
    for (int r = first; r < first + count; r++) begin
      if (tbl_gap[r] > 0) begin
        s_valid <= 1'b0;
        repeat (tbl_gap[r]) @(posedge clk);
      end
      for (int c = 0; c < NCH; c++) s_data.smp[c] <= tbl_smp[r][c];
      s_valid <= 1'b1;
      ready_seen = 1'b0;
      while (!ready_seen) begin
        @(negedge clk);
        ready_seen = s_ready;
        @(posedge clk);
      end
    end
    s_valid <= 1'b0;
  endtask

  task automatic wait_drain(input int expect_total);
    int target;
    target = (expect_total < DEPTH) ? expect_total : DEPTH;
    @(negedge clk);
    while (int'(ev_count) < target) @(negedge clk);
    if (expect_total > DEPTH) begin
      while (!overflow) @(negedge clk);
    end
    repeat (DRAIN_CYCLES) @(posedge clk);
  endtask

  task automatic read_buffer();
    int n;
    got_q.delete();
    @(negedge clk);
    n = int'(ev_count);
    for (int a = 0; a < n; a++) begin
      @(posedge clk);
      rd_addr <= ev_addr_t'(a);
      @(posedge clk);
      @(negedge clk);
      got_q.push_back(rd_event);
    end
  endtask

  // each source's logged events must be a prefix of its model sequence
  task automatic compare_events(input int expect_total);
    corr_event_t exp_s [$];
    corr_event_t got_s [$];
    string       tag;
    @(negedge clk);
    check(int'(ev_count), (expect_total < DEPTH) ? expect_total : DEPTH, "event count");
    check(int'(overflow), (expect_total > DEPTH) ? 1 : 0, "overflow flag");
    for (int s = 0; s < 2; s++) begin
      exp_s.delete();
      got_s.delete();
      foreach (exp_q[i]) if (exp_q[i].src == (s == 1)) exp_s.push_back(exp_q[i]);
      foreach (got_q[i]) if (got_q[i].src == (s == 1)) got_s.push_back(got_q[i]);
      if (expect_total <= DEPTH) begin
        check(got_s.size(), exp_s.size(), $sformatf("source %0d event count", s));
      end
      check(int'(got_s.size() <= exp_s.size()), 1, $sformatf("source %0d extra events", s));
      for (int i = 0; i < got_s.size() && i < exp_s.size(); i++) begin
        tag = $sformatf("source %0d event %0d", s, i);
        check(int'(got_s[i].chan), int'(exp_s[i].chan), {tag, " channel"});
        check(int'(got_s[i].beat), int'(exp_s[i].beat), {tag, " beat"});
        check(int'($signed(got_s[i].value)), int'($signed(exp_s[i].value)), {tag, " value"});
      end
    end
  endtask

  task automatic check_matched();
    int hits_a;
    int hits_b;
    hits_a = 0;
    hits_b = 0;
    foreach (got_q[i]) begin
      if (got_q[i].src) begin
        hits_b++;
      end else if (got_q[i].chan == chan_t'(2) && got_q[i].beat == beat_idx_t'(7) &&
                   int'($signed(got_q[i].value)) == 400) begin
        hits_a++;
      end
    end
    check(hits_a, 1, "code A peak on channel 2 at beat 7");
    check(hits_b, 0, "code B events from the code A pattern");
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    int errs_before;
    int n_total;
    clk        = 1'b0;
    arst_n     = 1'b0;
    s_valid    = 1'b0;
    s_data     = '0;
    rd_addr    = '0;
    rng_state  = 32'h06f99da4;
    err_cnt    = 0;
    check_cnt  = 0;
    fail_tests = 0;
    build_table();
    for (int t = 0; t < N_TESTS; t++) begin
      errs_before = err_cnt;
      apply_reset();
      run_model(test_first[t], test_len[t]);
      n_total = exp_q.size();
      send_rows(test_first[t], test_len[t]);
      wait_drain(n_total);
      read_buffer();
      compare_events(n_total);
      if (t == 1) begin
        check_matched();
      end else if (t == 4) begin
        check(int'(ev_count), DEPTH, "event count saturated at the buffer depth");
        check(int'(overflow), 1, "overflow flag after more events than the buffer holds");
      end
      if (err_cnt == errs_before) begin
        $display("test %0d %s: ok, %0d events expected", t + 1, test_name[t], n_total);
      end else begin
        fail_tests++;
        $display("test %0d %s: %0d errors", t + 1, test_name[t], err_cnt - errs_before);
      end
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             N_TESTS, fail_tests, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
